/* source/mvp_pkg.sv */
package mvp_pkg;

    // ========================================================================
    // core dimensions
    // ========================================================================

    localparam int LANES          = 4;
    localparam int LANE_WIDTH     = 16;
    localparam int REG_DEPTH      = 32;
    localparam int REG_ADDR_WIDTH = $clog2(REG_DEPTH);
    localparam int MEM_ADDR_WIDTH = 12;
    localparam int PC_WIDTH       = 8;
    localparam int INSTR_WIDTH    = 32;
    localparam int OP_WIDTH       = 5;

    typedef logic [LANE_WIDTH-1:0]     lane_t;
    typedef lane_t [LANES-1:0]         vec_t;
    typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;
    typedef logic [MEM_ADDR_WIDTH-1:0] mem_addr_t;
    typedef logic [PC_WIDTH-1:0]       pc_t;
    typedef logic [INSTR_WIDTH-1:0]    instr_t;

    // opcode field values, anything else decodes as NOP
    typedef enum logic [OP_WIDTH-1:0] {
        NOP  = 5'd0,
        VADD = 5'd1,
        VSUB = 5'd2,
        VAND = 5'd3,
        VOR  = 5'd4,
        VXOR = 5'd5,
        VLD  = 5'd6,
        VST  = 5'd7,
        HALT = 5'd8
    } op_e;

    typedef enum logic {
        RUN    = 1'b0,
        HALTED = 1'b1
    } fetch_state_e;

    // ========================================================================
    // instruction layout and stage payloads
    // ========================================================================

    // op 31:27, vd 26:22, vs1 21:17, vs2 16:12, addr 11:0
    typedef struct packed {
        logic [OP_WIDTH-1:0] opcode;
        reg_addr_t           vd;
        reg_addr_t           vs1;
        reg_addr_t           vs2;
        mem_addr_t           addr;
    } instr_fmt_t;

    typedef struct packed {
        op_e       op;
        reg_addr_t vd;
        reg_addr_t vs1;
        reg_addr_t vs2;
        mem_addr_t addr;
        logic      reg_we;
        logic      mem_we;
        logic      mem_ren;
    } decoded_t;

    // one result heading for the register file
    typedef struct packed {
        logic      reg_we;
        reg_addr_t vd;
        vec_t      data;
    } wb_t;

endpackage

/* source/fetch_unit.sv */
`timescale 1ns/10ps

module fetch_unit (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        en,
    input  logic        halt_seen,
    output mvp_pkg::pc_t pc,
    output logic        halted
);

    mvp_pkg::fetch_state_e state;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= mvp_pkg::RUN;
            pc    <= '0;
        end else if (en) begin
            case (state)
                mvp_pkg::RUN: begin
                    // stop on the halt word, pc stays pointing at it
                    if (halt_seen) begin
                        state <= mvp_pkg::HALTED;
                    end else begin
                        pc <= mvp_pkg::pc_t'(pc + 1'b1);
                    end
                end
                default: begin
                    state <= mvp_pkg::HALTED;
                end
            endcase
        end
    end

    assign halted = (state == mvp_pkg::HALTED);

endmodule

/* source/decode_unit.sv */
`timescale 1ns/10ps

module decode_unit (
    input  mvp_pkg::instr_t   instr,
    input  logic              halted,
    output mvp_pkg::decoded_t ctrl,
    output logic              halt_seen
);

    mvp_pkg::instr_fmt_t fields;

    assign fields = mvp_pkg::instr_fmt_t'(instr);

    // halt only counts while fetch is still running
    assign halt_seen = !halted && (fields.opcode == mvp_pkg::HALT);

    always_comb begin
        ctrl = '0;
        ctrl.op = mvp_pkg::NOP;
        // nothing issues once fetch has stopped
        if (!halted) begin
            ctrl.vd   = fields.vd;
            ctrl.vs1  = fields.vs1;
            ctrl.vs2  = fields.vs2;
            ctrl.addr = fields.addr;
            case (fields.opcode)
                mvp_pkg::VADD,
                mvp_pkg::VSUB,
                mvp_pkg::VAND,
                mvp_pkg::VOR,
                mvp_pkg::VXOR: begin
                    ctrl.op     = mvp_pkg::op_e'(fields.opcode);
                    ctrl.reg_we = 1'b1;
                end
                mvp_pkg::VLD: begin
                    ctrl.op      = mvp_pkg::VLD;
                    ctrl.reg_we  = 1'b1;
                    ctrl.mem_ren = 1'b1;
                end
                // store data comes from vs2
                mvp_pkg::VST: begin
                    ctrl.op     = mvp_pkg::VST;
                    ctrl.mem_we = 1'b1;
                end
                mvp_pkg::HALT: begin
                    ctrl.op = mvp_pkg::HALT;
                end
                default: begin
                    ctrl.op = mvp_pkg::NOP;
                end
            endcase
        end
    end

endmodule

/* source/vector_regfile.sv */
`timescale 1ns/10ps

module vector_regfile (
    input  logic               clk,
    input  logic               rst_n,
    input  mvp_pkg::wb_t       wr,
    input  logic               wr_en,
    input  mvp_pkg::reg_addr_t rd_addr_a,
    input  mvp_pkg::reg_addr_t rd_addr_b,
    output mvp_pkg::vec_t      rd_data_a,
    output mvp_pkg::vec_t      rd_data_b
);

    mvp_pkg::vec_t regs [mvp_pkg::REG_DEPTH];
    logic          wr_act;

    assign wr_act = wr_en && wr.reg_we;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < mvp_pkg::REG_DEPTH; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_act) begin
            regs[wr.vd] <= wr.data;
        end
    end

    // write-first, a same-cycle write shows on the read port
    assign rd_data_a = (wr_act && wr.vd == rd_addr_a) ? wr.data : regs[rd_addr_a];
    assign rd_data_b = (wr_act && wr.vd == rd_addr_b) ? wr.data : regs[rd_addr_b];

    a_wr_addr_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        wr_act |-> !$isunknown(wr.vd)
    ) else $error("register write with unknown index");

endmodule

/* source/vector_alu.sv */
`timescale 1ns/10ps

module vector_alu (
    input  logic          clk,
    input  logic          en,
    input  mvp_pkg::op_e  op,
    input  mvp_pkg::vec_t a,
    input  mvp_pkg::vec_t b,
    output mvp_pkg::vec_t result
);

    mvp_pkg::vec_t lane_res;

    // lane-wise, 16-bit add and sub wrap around
    always_comb begin
        for (int i = 0; i < mvp_pkg::LANES; i++) begin
            case (op)
                mvp_pkg::VADD: begin
                    lane_res[i] = a[i] + b[i];
                end
                mvp_pkg::VSUB: begin
                    lane_res[i] = a[i] - b[i];
                end
                mvp_pkg::VAND: begin
                    lane_res[i] = a[i] & b[i];
                end
                mvp_pkg::VOR: begin
                    lane_res[i] = a[i] | b[i];
                end
                mvp_pkg::VXOR: begin
                    lane_res[i] = a[i] ^ b[i];
                end
                // loads, stores, nop and halt
                default: begin
                    lane_res[i] = '0;
                end
            endcase
        end
    end

    // result lands in the MEM stage
    always_ff @(posedge clk) begin
        if (en) begin
            result <= lane_res;
        end
    end

endmodule

/* source/operand_forward.sv */
`timescale 1ns/10ps

module operand_forward (
    input  mvp_pkg::reg_addr_t src_a,
    input  mvp_pkg::reg_addr_t src_b,
    input  mvp_pkg::vec_t      reg_a,
    input  mvp_pkg::vec_t      reg_b,
    input  mvp_pkg::wb_t       mem_stage,
    input  mvp_pkg::wb_t       wb_stage,
    output mvp_pkg::vec_t      op_a,
    output mvp_pkg::vec_t      op_b
);

    // youngest producer wins, the register value is the fallback
    function automatic mvp_pkg::vec_t pick(
        input mvp_pkg::reg_addr_t src,
        input mvp_pkg::vec_t      reg_val,
        input mvp_pkg::wb_t       mem_res,
        input mvp_pkg::wb_t       wb_res
    );
        mvp_pkg::vec_t val;
        if (mem_res.reg_we && mem_res.vd == src) begin
            val = mem_res.data;
        end else if (wb_res.reg_we && wb_res.vd == src) begin
            val = wb_res.data;
        end else begin
            val = reg_val;
        end
        return val;
    endfunction

    always_comb begin
        op_a = pick(src_a, reg_a, mem_stage, wb_stage);
    end

    // vs2 also feeds store data
    always_comb begin
        op_b = pick(src_b, reg_b, mem_stage, wb_stage);
    end

endmodule

/* source/mvp_core.sv */
`timescale 1ns/10ps

module mvp_core (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 en,

    output mvp_pkg::pc_t         pc,
    input  mvp_pkg::instr_t      instr,

    output mvp_pkg::mem_addr_t   mem_addr,
    output logic                 mem_ren,
    output logic                 mem_we,
    output mvp_pkg::vec_t        mem_wdata,
    input  mvp_pkg::vec_t        mem_rdata,

    output logic                 data_out_vld,
    output mvp_pkg::vec_t        data_out,
    output mvp_pkg::reg_addr_t   reg_wb,
    output logic                 halted
);

    mvp_pkg::decoded_t id_ctrl;
    mvp_pkg::decoded_t ex_ctrl;
    mvp_pkg::decoded_t mem_ctrl;
    logic              halt_seen;
    mvp_pkg::vec_t     id_a;
    mvp_pkg::vec_t     id_b;
    mvp_pkg::vec_t     ex_a;
    mvp_pkg::vec_t     ex_b;
    mvp_pkg::vec_t     fwd_a;
    mvp_pkg::vec_t     fwd_b;
    mvp_pkg::vec_t     alu_res;
    mvp_pkg::vec_t     ld_data;
    mvp_pkg::vec_t     rdata_hold;
    logic              rdata_pending;
    mvp_pkg::wb_t      mem_wb;
    mvp_pkg::wb_t      wb_q;

    // ========================================================================
    // ID
    // ========================================================================

    fetch_unit u_fetch (
        .clk       (clk      ),
        .rst_n     (rst_n    ),
        .en        (en       ),
        .halt_seen (halt_seen),
        .pc        (pc       ),
        .halted    (halted   )
    );

    decode_unit u_decode (
        .instr     (instr    ),
        .halted    (halted   ),
        .ctrl      (id_ctrl  ),
        .halt_seen (halt_seen)
    );

    vector_regfile u_regfile (
        .clk       (clk        ),
        .rst_n     (rst_n      ),
        .wr        (wb_q       ),
        .wr_en     (en         ),
        .rd_addr_a (id_ctrl.vs1),
        .rd_addr_b (id_ctrl.vs2),
        .rd_data_a (id_a       ),
        .rd_data_b (id_b       )
    );

    // ========================================================================
    // EX, memory port driven from here
    // ========================================================================

    operand_forward u_forward (
        .src_a     (ex_ctrl.vs1),
        .src_b     (ex_ctrl.vs2),
        .reg_a     (ex_a       ),
        .reg_b     (ex_b       ),
        .mem_stage (mem_wb     ),
        .wb_stage  (wb_q       ),
        .op_a      (fwd_a      ),
        .op_b      (fwd_b      )
    );

    vector_alu u_alu (
        .clk    (clk       ),
        .en     (en        ),
        .op     (ex_ctrl.op),
        .a      (fwd_a     ),
        .b      (fwd_b     ),
        .result (alu_res   )
    );

    assign mem_addr  = ex_ctrl.addr;
    assign mem_ren   = en && ex_ctrl.mem_ren;
    assign mem_we    = en && ex_ctrl.mem_we;
    assign mem_wdata = fwd_b;

    // ========================================================================
    // MEM, write-back select
    // ========================================================================

    // read data is only valid the cycle after mem_ren, keep it for en stalls
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rdata_pending <= 1'b0;
        end else begin
            rdata_pending <= mem_ren;
        end
    end

    always_ff @(posedge clk) begin
        if (rdata_pending) begin
            rdata_hold <= mem_rdata;
        end
    end

    assign ld_data = rdata_pending ? mem_rdata : rdata_hold;

    always_comb begin
        mem_wb.reg_we = mem_ctrl.reg_we;
        mem_wb.vd     = mem_ctrl.vd;
        mem_wb.data   = (mem_ctrl.op == mvp_pkg::VLD) ? ld_data : alu_res;
    end

    // ========================================================================
    // stage registers
    // ========================================================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_ctrl  <= '0;
            mem_ctrl <= '0;
            wb_q     <= '0;
        end else if (en) begin
            ex_ctrl  <= id_ctrl;
            mem_ctrl <= ex_ctrl;
            wb_q     <= mem_wb;
        end
    end

    // operand payload
    always_ff @(posedge clk) begin
        if (en) begin
            ex_a <= id_a;
            ex_b <= id_b;
        end
    end

    // WB observation port
    assign data_out_vld = en && wb_q.reg_we;
    assign data_out     = wb_q.data;
    assign reg_wb       = wb_q.vd;

    a_mem_excl: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(mem_ren && mem_we)
    ) else $error("mem_ren and mem_we both high");

    a_no_wb_in_reset: assert property (
        @(posedge clk)
        (!rst_n && $past(!rst_n)) |-> !data_out_vld
    ) else $error("data_out_vld high during reset");

endmodule

/* tb/tb_mvp_core.sv */
`timescale 1ns/10ps

module tb_mvp_core;

    logic                clk;
    logic                rst_n = 1'b0;
    logic                en = 1'b0;
    mvp_pkg::pc_t        pc;
    mvp_pkg::instr_t     instr;
    mvp_pkg::mem_addr_t  mem_addr;
    logic                mem_ren;
    logic                mem_we;
    mvp_pkg::vec_t       mem_wdata;
    mvp_pkg::vec_t       mem_rdata = '0;
    logic                data_out_vld;
    mvp_pkg::vec_t       data_out;
    mvp_pkg::reg_addr_t  reg_wb;
    logic                halted;

    mvp_pkg::instr_t     prog [256];
    mvp_pkg::vec_t       dmem [4096];
    mvp_pkg::vec_t       init_img [4096];
    mvp_pkg::vec_t       model_mem [4096];

    // expected results, filled by the reference model
    mvp_pkg::reg_addr_t  exp_vd [256];
    mvp_pkg::vec_t       exp_data [256];
    mvp_pkg::mem_addr_t  exp_st_addr [256];
    mvp_pkg::vec_t       exp_st_data [256];
    mvp_pkg::mem_addr_t  exp_ld_addr [256];
    int                  wb_n;
    int                  st_n;
    int                  ld_n;
    int                  wb_idx;
    int                  st_idx;
    int                  ld_idx;
    int                  cyc = 0;
    int                  first_vld;
    int                  start_cyc;
    int                  prog_len;
    int                  seed;

    mvp_core uut (
        .clk          (clk         ),
        .rst_n        (rst_n       ),
        .en           (en          ),
        .pc           (pc          ),
        .instr        (instr       ),
        .mem_addr     (mem_addr    ),
        .mem_ren      (mem_ren     ),
        .mem_we       (mem_we      ),
        .mem_wdata    (mem_wdata   ),
        .mem_rdata    (mem_rdata   ),
        .data_out_vld (data_out_vld),
        .data_out     (data_out    ),
        .reg_wb       (reg_wb      ),
        .halted       (halted      )
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // combinational program memory
    assign instr = prog[pc];

    // data memory, reloaded from the image while in reset, one-cycle reads
    always @(posedge clk) begin
        if (!rst_n) begin
            for (int a = 0; a < 4096; a++) begin
                dmem[a] <= init_img[a];
            end
            mem_rdata <= '0;
        end else begin
            if (mem_we) begin
                dmem[mem_addr] <= mem_wdata;
            end
            if (mem_ren) begin
                mem_rdata <= dmem[mem_addr];
            end
        end
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("Fail %s: got %h expected %h", name, got, exp));
        end
    endtask

    // ========================================================================
    // write-back, load and store monitor
    // ========================================================================

    always @(negedge clk) begin
        if (!rst_n) begin
            wb_idx = 0;
            st_idx = 0;
            ld_idx = 0;
            first_vld = -1;
        end else begin
            if (data_out_vld) begin
                if (first_vld < 0) begin
                    first_vld = cyc;
                end
                if (wb_idx >= wb_n) begin
                    stop_run("write-back seen when none was expected");
                end
                check("reg_wb", 64'(reg_wb), 64'(exp_vd[wb_idx]));
                check("data_out", data_out, exp_data[wb_idx]);
                wb_idx++;
            end
            if (mem_we) begin
                if (st_idx >= st_n) begin
                    stop_run("store seen when none was expected");
                end
                check("mem_addr", 64'(mem_addr), 64'(exp_st_addr[st_idx]));
                check("mem_wdata", mem_wdata, exp_st_data[st_idx]);
                st_idx++;
            end
            if (mem_ren) begin
                if (ld_idx >= ld_n) begin
                    stop_run("load seen when none was expected");
                end
                check("mem_addr", 64'(mem_addr), 64'(exp_ld_addr[ld_idx]));
                ld_idx++;
            end
        end
        cyc++;
    end

    // ========================================================================
    // program building and reference model
    // ========================================================================

    function automatic mvp_pkg::instr_t encode_instr(input mvp_pkg::op_e op, input int vd,
                                                     input int vs1, input int vs2,
                                                     input int addr);
        return {op, 5'(vd), 5'(vs1), 5'(vs2), 12'(addr)};
    endfunction

    task automatic add_instr(input mvp_pkg::op_e op, input int vd, input int vs1,
                             input int vs2, input int addr);
        prog[prog_len] = encode_instr(op, vd, vs1, vs2, addr);
        prog_len++;
    endtask

    // unused slots hold HALT
    task automatic clear_program();
        for (int i = 0; i < 256; i++) begin
            prog[i] = encode_instr(mvp_pkg::HALT, 0, 0, 0, 0);
        end
        prog_len = 0;
    endtask

    task automatic fill_memory();
        for (int a = 0; a < 4096; a++) begin
            for (int l = 0; l < mvp_pkg::LANES; l++) begin
                init_img[a][l] = 16'($random(seed));
            end
        end
    endtask

    task automatic model_run(output int halt_pc);
        mvp_pkg::vec_t      regs [mvp_pkg::REG_DEPTH];
        mvp_pkg::vec_t      a;
        mvp_pkg::vec_t      b;
        mvp_pkg::vec_t      r;
        logic [4:0]         opc;
        mvp_pkg::reg_addr_t vd;
        mvp_pkg::mem_addr_t addr;
        int                 p;
        for (int i = 0; i < mvp_pkg::REG_DEPTH; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < 4096; i++) begin
            model_mem[i] = init_img[i];
        end
        wb_n = 0;
        st_n = 0;
        ld_n = 0;
        halt_pc = -1;
        p = 0;
        while (halt_pc < 0) begin
            if (p > 255) begin
                stop_run("program runs past the end without a HALT");
            end
            opc = prog[p][31:27];
            vd = prog[p][26:22];
            a = regs[prog[p][21:17]];
            b = regs[prog[p][16:12]];
            addr = prog[p][11:0];
            if (opc == mvp_pkg::HALT) begin
                halt_pc = p;
            end else if (opc == mvp_pkg::VST) begin
                model_mem[addr] = b;
                exp_st_addr[st_n] = addr;
                exp_st_data[st_n] = b;
                st_n++;
            end else if (opc == mvp_pkg::VLD ||
                         (opc >= mvp_pkg::VADD && opc <= mvp_pkg::VXOR)) begin
                if (opc == mvp_pkg::VLD) begin
                    exp_ld_addr[ld_n] = addr;
                    ld_n++;
                end
                for (int l = 0; l < mvp_pkg::LANES; l++) begin
                    case (opc)
                        mvp_pkg::VADD: r[l] = a[l] + b[l];
                        mvp_pkg::VSUB: r[l] = a[l] - b[l];
                        mvp_pkg::VAND: r[l] = a[l] & b[l];
                        mvp_pkg::VOR:  r[l] = a[l] | b[l];
                        mvp_pkg::VXOR: r[l] = a[l] ^ b[l];
                        default:       r[l] = model_mem[addr][l];
                    endcase
                end
                regs[vd] = r;
                exp_vd[wb_n] = vd;
                exp_data[wb_n] = r;
                wb_n++;
            end
            p++;
        end
    endtask

    // ========================================================================
    // DUT control
    // ========================================================================

    task automatic reset_dut();
        @(posedge clk);
        #5;
        rst_n = 1'b0;
        en = 1'b0;
        repeat (16) @(posedge clk);
        #5;
        rst_n = 1'b1;
        en = 1'b1;
        start_cyc = cyc;
        check("pc", 64'(pc), 64'd0);
    endtask

    // en drops for stall_len cycles once stall_at cycles have passed
    task automatic run_program(input int stall_at, input int stall_len, input bit check_lat);
        int           halt_pc;
        int           k;
        mvp_pkg::pc_t held;
        model_run(halt_pc);
        reset_dut();
        k = 0;
        while (!halted) begin
            if (k == stall_at) begin
                held = pc;
                en = 1'b0;
                for (int j = 0; j < stall_len; j++) begin
                    @(negedge clk);
                    check("pc", 64'(pc), 64'(held));
                    check("data_out_vld", 64'(data_out_vld), 64'd0);
                    check("mem_we", 64'(mem_we), 64'd0);
                    check("mem_ren", 64'(mem_ren), 64'd0);
                    @(posedge clk);
                    #5;
                end
                en = 1'b1;
            end
            @(posedge clk);
            #5;
            k++;
            if (k > 600) begin
                stop_run("timeout waiting for halted");
            end
        end
        // drain, pc must stay on the HALT word
        held = pc;
        for (int j = 0; j < 20; j++) begin
            @(negedge clk);
            check("pc", 64'(pc), 64'(held));
        end
        check("pc", 64'(pc), 64'(halt_pc));
        check("halted", 64'(halted), 64'd1);
        check("write-back count", 64'(wb_idx), 64'(wb_n));
        check("store count", 64'(st_idx), 64'(st_n));
        check("load count", 64'(ld_idx), 64'(ld_n));
        if (check_lat) begin
            check("write-back latency", 64'(first_vld - start_cyc), 64'd3);
        end
        for (int a = 0; a < 4096; a++) begin
            check($sformatf("dmem[%0h]", a), dmem[a], model_mem[a]);
        end
    endtask

    // ========================================================================
    // directed tests
    // ========================================================================

    task automatic alu_dependency_test();
        fill_memory();
        clear_program();
        add_instr(mvp_pkg::VLD, 1, 0, 0, 12'h010);
        add_instr(mvp_pkg::VLD, 2, 0, 0, 12'h7ff);
        add_instr(mvp_pkg::VADD, 3, 1, 2, 0);
        add_instr(mvp_pkg::VSUB, 4, 3, 1, 0);
        add_instr(mvp_pkg::VAND, 5, 4, 3, 0);
        add_instr(mvp_pkg::VOR, 6, 5, 3, 0);
        add_instr(mvp_pkg::VXOR, 7, 6, 3, 0);
        add_instr(mvp_pkg::VADD, 7, 7, 7, 0);
        add_instr(mvp_pkg::VSUB, 8, 7, 6, 0);
        add_instr(mvp_pkg::VXOR, 3, 3, 8, 0);
        run_program(-1, 0, 1'b0);
    endtask

    task automatic store_result_test();
        fill_memory();
        clear_program();
        add_instr(mvp_pkg::VLD, 1, 0, 0, 12'h005);
        add_instr(mvp_pkg::VLD, 2, 0, 0, 12'h006);
        add_instr(mvp_pkg::VADD, 3, 1, 2, 0);
        add_instr(mvp_pkg::VST, 0, 0, 3, 12'h100);
        add_instr(mvp_pkg::VXOR, 4, 3, 1, 0);
        add_instr(mvp_pkg::VST, 0, 0, 4, 12'h101);
        add_instr(mvp_pkg::VST, 0, 0, 1, 12'hfff);
        run_program(-1, 0, 1'b0);
    endtask

    task automatic load_use_test();
        fill_memory();
        clear_program();
        add_instr(mvp_pkg::VLD, 1, 0, 0, 12'h020);
        add_instr(mvp_pkg::VADD, 2, 1, 1, 0);
        add_instr(mvp_pkg::VLD, 3, 0, 0, 12'h021);
        add_instr(mvp_pkg::VSUB, 4, 3, 2, 0);
        add_instr(mvp_pkg::VST, 0, 0, 4, 12'h030);
        add_instr(mvp_pkg::VLD, 6, 0, 0, 12'h030);
        add_instr(mvp_pkg::VAND, 7, 6, 4, 0);
        run_program(-1, 0, 1'b0);
    endtask

    // stall lands while the store sits in EX and a result waits in WB
    task automatic stall_timing_test();
        fill_memory();
        clear_program();
        add_instr(mvp_pkg::VLD, 1, 0, 0, 12'h001);
        add_instr(mvp_pkg::VADD, 2, 1, 1, 0);
        add_instr(mvp_pkg::VSUB, 3, 2, 1, 0);
        add_instr(mvp_pkg::VXOR, 4, 3, 2, 0);
        add_instr(mvp_pkg::VOR, 5, 4, 3, 0);
        add_instr(mvp_pkg::VST, 0, 0, 5, 12'h040);
        add_instr(mvp_pkg::VAND, 6, 5, 4, 0);
        run_program(6, 5, 1'b1);
    endtask

    task automatic random_program_test();
        int           pick;
        mvp_pkg::op_e op;
        fill_memory();
        clear_program();
        for (int i = 0; i < 40; i++) begin
            pick = ($random(seed) & 32'h7fff_ffff) % 7;
            op = mvp_pkg::op_e'(5'(pick + 1));
            add_instr(op, $random(seed) & 7, $random(seed) & 7, $random(seed) & 7,
                      $random(seed) & 63);
        end
        run_program(-1, 0, 1'b0);
    endtask

    // words after HALT must never issue
    task automatic halt_test();
        fill_memory();
        clear_program();
        add_instr(mvp_pkg::VLD, 1, 0, 0, 12'h002);
        add_instr(mvp_pkg::VADD, 2, 1, 1, 0);
        add_instr(mvp_pkg::HALT, 0, 0, 0, 0);
        add_instr(mvp_pkg::VADD, 3, 2, 2, 0);
        add_instr(mvp_pkg::VST, 0, 0, 2, 12'h050);
        add_instr(mvp_pkg::VLD, 4, 0, 0, 12'h003);
        run_program(-1, 0, 1'b0);
    endtask

    initial begin
        seed = 32'h5317e215;
        rst_n = 1'b0;
        en = 1'b0;
        clear_program();
        alu_dependency_test();
        store_result_test();
        load_use_test();
        stall_timing_test();
        random_program_test();
        halt_test();
        $display("TESTS PASSED");
        $finish;
    end

endmodule

/* build.f */
source/mvp_pkg.sv
source/fetch_unit.sv
source/decode_unit.sv
source/vector_regfile.sv
source/vector_alu.sv
source/operand_forward.sv
source/mvp_core.sv
tb/tb_mvp_core.sv

/* run.sh */
#!/bin/sh
# compile and run the mvp_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_mvp_core \
    -f build.f --Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "TESTS PASSED"; then
    exit 0
fi
echo "pass message not found"
exit 1
